// ==== src/rv_settings.svh ====
//----------------------------------------------------------
// RV64 core settings.
// Data width, register count and the first fetch address.
//----------------------------------------------------------
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Register and memory data width.
`define RV_XLEN     64
// Architectural integer registers.
`define RV_NUM_REGS 32
`define RV_INSTR_W  32
// First fetch address after reset.
`define RV_RESET_PC 64'h0

`endif

// ==== src/rv_pkg.sv ====
//----------------------------------------------------------
// RV64 core types.
// Opcodes, ALU operations, FSM states and port structs.
//----------------------------------------------------------
`include "rv_settings.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] xlen_t;

    // Major opcodes of the kept instructions.
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        MEM_ADDR,
        MEM_ACCESS,
        WRITEBACK,
        BRANCH
    } ctrl_state_e;

    //----------------------------------------------------------
    // Datapath select codes.
    //----------------------------------------------------------
    localparam logic [1:0] SRC_A_PC     = 2'd0;
    localparam logic [1:0] SRC_A_OLD_PC = 2'd1;
    localparam logic [1:0] SRC_A_REG    = 2'd2;
    localparam logic [1:0] SRC_A_ZERO   = 2'd3;

    localparam logic [1:0] SRC_B_REG    = 2'd0;
    localparam logic [1:0] SRC_B_IMM    = 2'd1;
    localparam logic [1:0] SRC_B_FOUR   = 2'd2;

    localparam logic [2:0] IMM_I        = 3'd0;
    localparam logic [2:0] IMM_S        = 3'd1;
    localparam logic [2:0] IMM_B        = 3'd2;
    localparam logic [2:0] IMM_U        = 3'd3;
    localparam logic [2:0] IMM_J        = 3'd4;

    // Writeback source. Registered ALU result, MDR or live ALU output.
    localparam logic [1:0] RES_ALU_Q    = 2'd0;
    localparam logic [1:0] RES_MDR      = 2'd1;
    localparam logic [1:0] RES_ALU      = 2'd2;

    //----------------------------------------------------------
    // Structs.
    //----------------------------------------------------------
    typedef struct packed {
        logic  req;
        logic  we;
        xlen_t addr;
        xlen_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic  ack;
        xlen_t rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic       pc_we;
        logic       ir_we;
        logic       reg_we;
        logic       mdr_we;
        logic [1:0] alu_src_a;
        logic [1:0] alu_src_b;
        alu_op_e    alu_op;
        logic [2:0] imm_sel;
        logic [1:0] result_sel;
        logic       pc_from_alu;
    } dp_ctrl_t;

    typedef struct packed {
        opcode_e    opcode;
        logic [2:0] funct3;
        logic       funct7_b5;
        logic       zero;
    } dp_status_t;

endpackage

// ==== src/rv_regfile.sv ====
//----------------------------------------------------------
// Integer register file, two read ports and one write port.
//----------------------------------------------------------
`timescale 1ns/1ns
`include "rv_settings.svh"

module rv_regfile
    import rv_pkg::*;
(
    input  logic                            clk,
    input  logic                            i_reset,
    input  logic                            i_we,
    input  logic [$clog2(`RV_NUM_REGS)-1:0] i_raddr_1,
    input  logic [$clog2(`RV_NUM_REGS)-1:0] i_raddr_2,
    input  logic [$clog2(`RV_NUM_REGS)-1:0] i_waddr,
    input  xlen_t                           i_wdata,
    output xlen_t                           o_rdata_1,
    output xlen_t                           o_rdata_2
);

    xlen_t regs [`RV_NUM_REGS];

    // x0 is cleared by reset and never written.
    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_waddr != '0)) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    assign o_rdata_1 = regs[i_raddr_1];
    assign o_rdata_2 = regs[i_raddr_2];

endmodule

// ==== src/rv_alu.sv ====
//----------------------------------------------------------
// 64-bit integer ALU with zero flag.
//----------------------------------------------------------
`timescale 1ns/1ns
`include "rv_settings.svh"

module rv_alu
    import rv_pkg::*;
(
    input  alu_op_e i_op,
    input  xlen_t   i_src_a,
    input  xlen_t   i_src_b,
    output xlen_t   o_result,
    output logic    o_zero
);

    localparam int SHAMT_W = $clog2(`RV_XLEN);
    localparam int MSB     = `RV_XLEN - 1;

    logic [SHAMT_W-1:0] shamt;
    xlen_t              diff;
    logic               slt_flag;
    logic               sltu_flag;

    assign shamt = i_src_b[SHAMT_W-1:0];
    assign diff  = i_src_a - i_src_b;

    // With differing signs a is less when negative.
    // Otherwise the sign of the difference decides.
    assign slt_flag  = (i_src_a[MSB] ^ i_src_b[MSB]) ? i_src_a[MSB] : diff[MSB];
    assign sltu_flag = (i_src_a < i_src_b);

    always_comb begin
        case (i_op)
            ALU_ADD:  o_result = i_src_a + i_src_b;
            ALU_SUB:  o_result = diff;
            ALU_AND:  o_result = i_src_a & i_src_b;
            ALU_OR:   o_result = i_src_a | i_src_b;
            ALU_XOR:  o_result = i_src_a ^ i_src_b;
            ALU_SLL:  o_result = i_src_a << shamt;
            ALU_SRL:  o_result = i_src_a >> shamt;
            ALU_SRA:  o_result = xlen_t'($signed(i_src_a) >>> shamt);
            ALU_SLT:  o_result = xlen_t'(slt_flag);
            ALU_SLTU: o_result = xlen_t'(sltu_flag);
            default:  o_result = '0;
        endcase
    end

    assign o_zero = (o_result == '0);

endmodule

// ==== src/rv_ctrl_fsm.sv ====
//----------------------------------------------------------
// Multicycle control FSM.
// Sequences each instruction and runs the memory handshake.
//----------------------------------------------------------
`timescale 1ns/1ns

module rv_ctrl_fsm
    import rv_pkg::*;
(
    input  logic       clk,
    input  logic       i_reset,
    input  dp_status_t i_status,
    input  logic       i_ack,
    output dp_ctrl_t   o_ctrl,
    output logic       o_req,
    output logic       o_we,
    output logic       o_addr_is_pc
);

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    logic        req_q;
    logic        req_d;
    logic        mem_done;
    logic        is_store;
    alu_op_e     arith_op;

    // A transfer ends on the cycle ack is seen with req still high.
    assign mem_done = req_q & i_ack;
    assign is_store = (i_status.opcode == OPC_STORE);

    // ALU operation for OP and OP-IMM.
    always_comb begin
        case (i_status.funct3)
            3'b000: begin
                if (i_status.opcode == OPC_OP && i_status.funct7_b5) begin
                    arith_op = ALU_SUB;
                end else begin
                    arith_op = ALU_ADD;
                end
            end
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = i_status.funct7_b5 ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    //----------------------------------------------------------
    // Four-phase request.
    //----------------------------------------------------------
    always_comb begin
        req_d = req_q;
        if (mem_done) begin
            req_d = 1'b0;
        end else if (!req_q && !i_ack && (state_q == FETCH || state_q == MEM_ACCESS)) begin
            // New request only once the previous ack has gone low.
            req_d = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state_q <= FETCH;
            req_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            req_q   <= req_d;
        end
    end

    assign o_req        = req_q;
    assign o_we         = (state_q == MEM_ACCESS) && is_store;
    assign o_addr_is_pc = (state_q == FETCH);

    //----------------------------------------------------------
    // Next state and control word.
    //----------------------------------------------------------
    always_comb begin
        state_d = state_q;
        o_ctrl  = '0;
        case (state_q)
            FETCH: begin
                // PC + 4 goes straight into the PC with the instruction.
                o_ctrl.alu_src_a   = SRC_A_PC;
                o_ctrl.alu_src_b   = SRC_B_FOUR;
                o_ctrl.pc_from_alu = 1'b1;
                o_ctrl.pc_we       = mem_done;
                o_ctrl.ir_we       = mem_done;
                if (mem_done) begin
                    state_d = DECODE;
                end
            end
            DECODE: begin
                // Branch or jump target lands in the ALU result register.
                o_ctrl.alu_src_a = SRC_A_OLD_PC;
                o_ctrl.alu_src_b = SRC_B_IMM;
                o_ctrl.imm_sel   = (i_status.opcode == OPC_JAL) ? IMM_J : IMM_B;
                case (i_status.opcode)
                    OPC_OP, OPC_OP_IMM, OPC_LUI: state_d = EXECUTE;
                    OPC_LOAD, OPC_STORE:         state_d = MEM_ADDR;
                    OPC_BRANCH:                  state_d = BRANCH;
                    OPC_JAL:                     state_d = WRITEBACK;
                    default:                     state_d = FETCH;
                endcase
            end
            EXECUTE: begin
                if (i_status.opcode == OPC_LUI) begin
                    o_ctrl.alu_src_a = SRC_A_ZERO;
                    o_ctrl.alu_src_b = SRC_B_IMM;
                    o_ctrl.imm_sel   = IMM_U;
                end else begin
                    o_ctrl.alu_src_a = SRC_A_REG;
                    o_ctrl.alu_src_b = (i_status.opcode == OPC_OP) ? SRC_B_REG : SRC_B_IMM;
                    o_ctrl.imm_sel   = IMM_I;
                    o_ctrl.alu_op    = arith_op;
                end
                state_d = WRITEBACK;
            end
            MEM_ADDR, MEM_ACCESS: begin
                // Same sum in both states keeps the address steady.
                o_ctrl.alu_src_a = SRC_A_REG;
                o_ctrl.alu_src_b = SRC_B_IMM;
                o_ctrl.imm_sel   = is_store ? IMM_S : IMM_I;
                if (state_q == MEM_ADDR) begin
                    state_d = MEM_ACCESS;
                end else if (mem_done) begin
                    o_ctrl.mdr_we = !is_store;
                    state_d       = is_store ? FETCH : WRITEBACK;
                end
            end
            WRITEBACK: begin
                o_ctrl.reg_we = 1'b1;
                if (i_status.opcode == OPC_LOAD) begin
                    o_ctrl.result_sel = RES_MDR;
                end else if (i_status.opcode == OPC_JAL) begin
                    // Link is old PC + 4; the target was computed in DECODE.
                    o_ctrl.alu_src_a  = SRC_A_OLD_PC;
                    o_ctrl.alu_src_b  = SRC_B_FOUR;
                    o_ctrl.result_sel = RES_ALU;
                    o_ctrl.pc_we      = 1'b1;
                end else begin
                    o_ctrl.result_sel = RES_ALU_Q;
                end
                state_d = FETCH;
            end
            BRANCH: begin
                o_ctrl.alu_src_a = SRC_A_REG;
                o_ctrl.alu_src_b = SRC_B_REG;
                o_ctrl.alu_op    = ALU_SUB;
                // BEQ on zero, BNE on nonzero.
                o_ctrl.pc_we     = i_status.zero ^ i_status.funct3[0];
                state_d          = FETCH;
            end
            default: begin
                state_d = FETCH;
            end
        endcase
    end

endmodule

// ==== src/rv_datapath.sv ====
//----------------------------------------------------------
// Multicycle datapath.
// PC, IR and operand registers, immediates and result select.
//----------------------------------------------------------
`timescale 1ns/1ns
`include "rv_settings.svh"

module rv_datapath
    import rv_pkg::*;
(
    input  logic       clk,
    input  logic       i_reset,
    input  dp_ctrl_t   i_ctrl,
    input  logic       i_addr_is_pc,
    input  xlen_t      i_rdata,
    output dp_status_t o_status,
    output xlen_t      o_addr,
    output xlen_t      o_wdata
);

    xlen_t                  pc_q;
    xlen_t                  old_pc_q;
    xlen_t                  a_q;
    xlen_t                  b_q;
    xlen_t                  alu_q;
    xlen_t                  mdr_q;
    logic [`RV_INSTR_W-1:0] ir_q;
    logic [`RV_INSTR_W-1:0] fetched_instr;
    xlen_t                  rf_rdata_1;
    xlen_t                  rf_rdata_2;
    xlen_t                  imm_ext;
    xlen_t                  src_a;
    xlen_t                  src_b;
    xlen_t                  alu_out;
    xlen_t                  result;
    logic                   alu_zero;

    // Two instructions per fetched word, PC bit 2 picks the half.
    assign fetched_instr = pc_q[2] ? i_rdata[63:32] : i_rdata[31:0];

    //----------------------------------------------------------
    // Registers.
    //----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_reset) begin
            pc_q <= `RV_RESET_PC;
            ir_q <= '0;
        end else begin
            if (i_ctrl.pc_we) begin
                pc_q <= i_ctrl.pc_from_alu ? alu_out : alu_q;
            end
            if (i_ctrl.ir_we) begin
                ir_q <= fetched_instr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_ctrl.ir_we) begin
            old_pc_q <= pc_q;
        end
        if (i_ctrl.mdr_we) begin
            mdr_q <= i_rdata;
        end
        a_q   <= rf_rdata_1;
        b_q   <= rf_rdata_2;
        alu_q <= alu_out;
    end

    // Immediate extension.
    always_comb begin
        case (i_ctrl.imm_sel)
            IMM_I:   imm_ext = {{(`RV_XLEN-12){ir_q[31]}}, ir_q[31:20]};
            IMM_S:   imm_ext = {{(`RV_XLEN-12){ir_q[31]}}, ir_q[31:25], ir_q[11:7]};
            IMM_B:   imm_ext = {{(`RV_XLEN-13){ir_q[31]}}, ir_q[31], ir_q[7],
                                ir_q[30:25], ir_q[11:8], 1'b0};
            IMM_U:   imm_ext = {{(`RV_XLEN-32){ir_q[31]}}, ir_q[31:12], 12'b0};
            IMM_J:   imm_ext = {{(`RV_XLEN-21){ir_q[31]}}, ir_q[31], ir_q[19:12],
                                ir_q[20], ir_q[30:21], 1'b0};
            default: imm_ext = '0;
        endcase
    end

    //----------------------------------------------------------
    // Operand and result selection.
    //----------------------------------------------------------
    always_comb begin
        case (i_ctrl.alu_src_a)
            SRC_A_PC:     src_a = pc_q;
            SRC_A_OLD_PC: src_a = old_pc_q;
            SRC_A_REG:    src_a = a_q;
            SRC_A_ZERO:   src_a = '0;
        endcase
        case (i_ctrl.alu_src_b)
            SRC_B_REG:  src_b = b_q;
            SRC_B_IMM:  src_b = imm_ext;
            SRC_B_FOUR: src_b = xlen_t'(4);
            default:    src_b = '0;
        endcase
        case (i_ctrl.result_sel)
            RES_MDR: result = mdr_q;
            RES_ALU: result = alu_out;
            default: result = alu_q;
        endcase
    end

    rv_regfile u_regfile (
        .clk       ( clk          ),
        .i_reset   ( i_reset      ),
        .i_we      ( i_ctrl.reg_we ),
        .i_raddr_1 ( ir_q[19:15]  ),
        .i_raddr_2 ( ir_q[24:20]  ),
        .i_waddr   ( ir_q[11:7]   ),
        .i_wdata   ( result       ),
        .o_rdata_1 ( rf_rdata_1   ),
        .o_rdata_2 ( rf_rdata_2   )
    );

    rv_alu u_alu (
        .i_op     ( i_ctrl.alu_op ),
        .i_src_a  ( src_a         ),
        .i_src_b  ( src_b         ),
        .o_result ( alu_out       ),
        .o_zero   ( alu_zero      )
    );

    assign o_status = '{
        opcode:    opcode_e'(ir_q[6:0]),
        funct3:    ir_q[14:12],
        funct7_b5: ir_q[30],
        zero:      alu_zero
    };

    // Fetch uses the PC, loads and stores the computed address.
    assign o_addr  = i_addr_is_pc ? pc_q : alu_q;
    assign o_wdata = b_q;

endmodule

// ==== src/rv_core_top.sv ====
//----------------------------------------------------------
// RV64 multicycle core top.
// Joins the control FSM and datapath onto one memory port.
//----------------------------------------------------------
`timescale 1ns/1ns

module rv_core_top
    import rv_pkg::*;
(
    input  logic     clk,
    input  logic     i_reset,
    input  mem_rsp_t i_mem,
    output mem_req_t o_mem
);

    dp_ctrl_t   ctrl;
    dp_status_t status;
    logic       req;
    logic       we;
    logic       addr_is_pc;
    xlen_t      addr;
    xlen_t      wdata;

    rv_ctrl_fsm u_ctrl_fsm (
        .clk          ( clk        ),
        .i_reset      ( i_reset    ),
        .i_status     ( status     ),
        .i_ack        ( i_mem.ack  ),
        .o_ctrl       ( ctrl       ),
        .o_req        ( req        ),
        .o_we         ( we         ),
        .o_addr_is_pc ( addr_is_pc )
    );

    rv_datapath u_datapath (
        .clk          ( clk         ),
        .i_reset      ( i_reset     ),
        .i_ctrl       ( ctrl        ),
        .i_addr_is_pc ( addr_is_pc  ),
        .i_rdata      ( i_mem.rdata ),
        .o_status     ( status      ),
        .o_addr       ( addr        ),
        .o_wdata      ( wdata       )
    );

    // FSM owns the handshake, the datapath owns address and data.
    assign o_mem = '{req: req, we: we, addr: addr, wdata: wdata};

endmodule

// ==== verif/rv_core_asserts.sv ====
//----------------------------------------------------------
// Memory handshake and reset assertions for the core.
//----------------------------------------------------------
`timescale 1ns/1ns
`include "rv_settings.svh"

module rv_core_asserts
    import rv_pkg::*;
(
    input logic     clk,
    input logic     i_reset,
    input mem_rsp_t i_mem,
    input mem_req_t o_mem
);

    logic seen_req;
    int   assert_errors = 0;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            seen_req <= 1'b0;
        end else if (o_mem.req) begin
            seen_req <= 1'b1;
        end
    end

    a_reset_no_req: assert property (@(posedge clk) i_reset |=> !o_mem.req)
        else begin
            $error("req high after reset was sampled");
            assert_errors++;
        end

    a_first_fetch: assert property (@(posedge clk) disable iff (i_reset)
        (o_mem.req && !seen_req) |-> (!o_mem.we && o_mem.addr == `RV_RESET_PC))
        else begin
            $error("first request is not a read at the reset PC");
            assert_errors++;
        end

    // Request held stable until ack.
    a_req_stable: assert property (@(posedge clk) disable iff (i_reset)
        (o_mem.req && !i_mem.ack) |=> (o_mem.req && $stable(o_mem.we)
            && $stable(o_mem.addr) && $stable(o_mem.wdata)))
        else begin
            $error("request changed before ack");
            assert_errors++;
        end

    a_no_rise_on_ack: assert property (@(posedge clk) disable iff (i_reset)
        $rose(o_mem.req) |-> !$past(i_mem.ack))
        else begin
            $error("req rose while ack was high");
            assert_errors++;
        end

endmodule

bind rv_core_top rv_core_asserts u_rv_core_asserts (.*);

// ==== verif/rv_core_tb.sv ====
//----------------------------------------------------------
// RV64 multicycle core testbench.
// Memory responder with random ack delay, store checks.
//----------------------------------------------------------
`timescale 1ns/1ns

module rv_core_tb;
    import rv_pkg::*;

    localparam int MEM_WORDS      = 16;
    localparam int FILE_WORDS     = 23;
    localparam int NUM_INSTR      = 30;
    // Slowest instruction fits in 20 cycles with the worst ack delay.
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 20;

    logic     clk;
    logic     i_reset;
    mem_rsp_t i_mem;
    mem_req_t o_mem;

    logic [63:0] file_words [0:FILE_WORDS-1];
    logic [63:0] mem [0:MEM_WORDS-1];

    int     value_errors;
    int     other_errors;
    int     cycle_count;
    int     rec_idx;
    int     store_count;
    int     delay;
    logic   busy;
    integer seed;

    rv_core_top u_rv_core_top (
        .clk     ( clk     ),
        .i_reset ( i_reset ),
        .i_mem   ( i_mem   ),
        .o_mem   ( o_mem   )
    );

    always #10 clk = ~clk;

    //----------------------------------------------------------
    // Checks and end of run.
    //----------------------------------------------------------
    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic finish_run();
        int assert_errors;
        assert_errors = u_rv_core_top.u_rv_core_asserts.assert_errors;
        $display("Errors: %0d wrong values, %0d other, %0d assertions, %0d stores seen",
                 value_errors, other_errors, assert_errors, store_count);
        if (value_errors == 0 && other_errors == 0 && assert_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    // Compare one store with the next expected record.
    task automatic check_store(input logic [63:0] addr, input logic [63:0] data);
        if (file_words[rec_idx] === 64'hFFFF_FFFF_FFFF_FFFF) begin
            $display("Store to %h with no expected record left", addr);
            other_errors++;
        end else begin
            check_value($sformatf("store %0d address", store_count),
                        file_words[rec_idx], addr);
            check_value($sformatf("store %0d data", store_count),
                        file_words[rec_idx+1], data);
            rec_idx     += 2;
            store_count++;
        end
    endtask

    //----------------------------------------------------------
    // Memory responder.
    //----------------------------------------------------------
    always @(negedge clk) begin
        if (i_reset) begin
            i_mem <= '0;
            busy  = 1'b0;
        end else if (i_mem.ack) begin
            if (!o_mem.req) begin
                i_mem.ack <= 1'b0;
            end
        end else if (o_mem.req) begin
            if (!busy) begin
                busy  = 1'b1;
                delay = $random(seed) & 32'h3;
            end
            if (delay == 0) begin
                busy = 1'b0;
                if (o_mem.addr >= 64'(MEM_WORDS * 8)) begin
                    $display("Access to %h lies outside the memory", o_mem.addr);
                    other_errors++;
                    i_mem <= '{ack: 1'b1, rdata: '0};
                end else if (o_mem.we) begin
                    mem[o_mem.addr[6:3]] = o_mem.wdata;
                    i_mem <= '{ack: 1'b1, rdata: '0};
                    check_store(o_mem.addr, o_mem.wdata);
                    if (file_words[rec_idx] === 64'hFFFF_FFFF_FFFF_FFFF) begin
                        finish_run();
                    end
                end else begin
                    i_mem <= '{ack: 1'b1, rdata: mem[o_mem.addr[6:3]]};
                end
            end else begin
                delay--;
            end
        end
    end

    // Progress limit.
    always @(posedge clk) begin
        if (!i_reset) begin
            cycle_count++;
            if (cycle_count >= TIMEOUT_CYCLES) begin
                $display("Timeout after %0d cycles, the core stopped making progress",
                         cycle_count);
                other_errors++;
                finish_run();
            end
        end
    end

    initial begin
        clk          = 1'b0;
        i_reset      = 1'b1;
        i_mem        = '0;
        busy         = 1'b0;
        delay        = 0;
        seed         = 43;
        value_errors = 0;
        other_errors = 0;
        cycle_count  = 0;
        store_count  = 0;
        rec_idx      = MEM_WORDS;
        $readmemh("verif/rv_core_input.hex", file_words);
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = file_words[i];
        end
        repeat (3) @(negedge clk);
        i_reset = 1'b0;
    end

endmodule

// ==== verif/rv_core_input.hex ====
// Words 0 to 15: memory image, two instructions per word, then data at 0x78.
// Then expected stores as address word, value word, closed by an all-ones address.
00500113_07803083
12345237_FFD00193
40320233_00120233
07803383_06403C23
0021D333_002092B3
4021D333_0062C2B3
0062F2B3_12334313
0021A433_06503C23
00700013_003134B3
00740433_00940433
00311463_00310463
00211463_06203C23
06303C23_00210463
06203C23_008005EF
06803C23_00B40433
0123456789ABCDEF
0000000000000078
012345679BE01DF2
0000000000000078
2397530ECA86421C
0000000000000078
012345679BE01E60
FFFFFFFFFFFFFFFF

// ==== sim.f ====
+incdir+src
src/rv_pkg.sv
src/rv_regfile.sv
src/rv_alu.sv
src/rv_ctrl_fsm.sv
src/rv_datapath.sv
src/rv_core_top.sv
verif/rv_core_asserts.sv
verif/rv_core_tb.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - include_dirs:
      - src
    files:
      - src/rv_pkg.sv
      - src/rv_regfile.sv
      - src/rv_alu.sv
      - src/rv_ctrl_fsm.sv
      - src/rv_datapath.sv
      - src/rv_core_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verif/rv_core_asserts.sv
      - verif/rv_core_tb.sv
